// ==== bench/sha512_sva.sv ====
/* SHA-512 core checker */
`timescale 1ns/1ps
`include "sha512_defines.svh"

module sha512_sva (
  input logic                    clk,
  input logic                    reset_n,
  input logic                    zeroize,
  input logic                    init_cmd,
  input logic                    next_cmd,
  input logic                    ready,
  input logic                    digest_valid,
  input logic [6:0]              round,
  input sha512_pkg::core_state_e state
);
  import sha512_pkg::*;

  // Count of failed assertions
  int fail_count = 0;

  // Busy span is the 80 rounds plus the final addition
  ready_low_while_busy: assert property (
    @(posedge clk) disable iff (!reset_n || zeroize)
    (init_cmd || next_cmd) && state == CORE_IDLE |=>
      !ready [*`SHA512_ROUNDS + 1] ##1 ready
  ) else begin
    $error("ready not low for exactly the busy span");
    fail_count++;
  end

  // Accepted command drops digest_valid
  valid_drops_on_cmd: assert property (
    @(posedge clk) disable iff (!reset_n)
    (init_cmd || next_cmd) && state == CORE_IDLE && !zeroize |=> !digest_valid
  ) else begin
    $error("digest_valid stayed high after an accepted command");
    fail_count++;
  end

  // Rounds end only after the last one
  done_after_last_round: assert property (
    @(posedge clk) disable iff (!reset_n)
    state == CORE_ROUNDS && round != 7'(`SHA512_ROUNDS - 1) |=> state != CORE_DONE
  ) else begin
    $error("CORE_DONE entered before round 79");
    fail_count++;
  end

endmodule

bind sha512_core sha512_sva i_sha512_sva (
  .clk          (clk),
  .reset_n      (reset_n),
  .zeroize      (zeroize),
  .init_cmd     (init_cmd),
  .next_cmd     (next_cmd),
  .ready        (ready),
  .digest_valid (digest_valid),
  .round        (round),
  .state        (state)
);

// ==== bench/sha512_tb.sv ====
/* SHA-512 engine testbench */
`timescale 1ns/1ps
`include "sha512_defines.svh"

module sha512_tb;
  import sha512_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int POLL_LIMIT = 200;

  // ----------------------------------------
  // FIPS 180-4 reference digests
  // ----------------------------------------
  localparam logic [511:0] EXP_ABC_512 = {
    64'hddaf35a193617aba, 64'hcc417349ae204131, 64'h12e6fa4e89a97ea2, 64'h0a9eeee64b55d39a,
    64'h2192992a274fc1a8, 64'h36ba3c23a3feebbd, 64'h454d4423643ce80e, 64'h2a9ac94fa54ca49f};
  localparam logic [511:0] EXP_TWO_512 = {
    64'h8e959b75dae313da, 64'h8cf4f72814fc143f, 64'h8f7779c6eb9f7fa1, 64'h7299aeadb6889018,
    64'h501d289e4900f7e4, 64'h331b99dec4b5433a, 64'hc7d329eeb6dd2654, 64'h5e96e55b874be909};
  localparam logic [511:0] EXP_ABC_384 = {
    64'hcb00753f45a35e8b, 64'hb5a03d699ac65007, 64'h272c32ab0eded163, 64'h1a8b605a43ff5bed,
    64'h8086072ba1e7cc23, 64'h58baeca134c825a7, 128'h0};
  localparam logic [511:0] EXP_ABC_256 = {
    64'h53048e2681941ef9, 64'h9b2e29b76b4c7dab, 64'he4c2d0c634fc6d46, 64'he0e2f13107e7af23,
    256'h0};
  // Only 224 bits survive, so word 3 keeps its top half
  localparam logic [511:0] EXP_ABC_224 = {
    64'h4634270f707b6a54, 64'hdaae7530460842e2, 64'h0e37ed265ceee9a4, 64'h3e8924aa00000000,
    256'h0};

  logic         clk;
  logic         reset_n;
  logic         cs;
  logic         we;
  logic [31:0]  address;
  sha512_word_t write_data;
  sha512_word_t read_data;
  logic         err;
  logic         notif_intr;

  logic [7:0] msg [0:255];
  logic [7:0] padded [0:255];
  int         nblocks;
  integer     seed = 44471;
  int         errors = 0;
  int         test_start = 0;
  int         tests_run = 0;
  int         tests_failed = 0;

  sha512 i_sha512 (
    .clk        (clk),
    .reset_n    (reset_n),
    .cs         (cs),
    .we         (we),
    .address    (address),
    .write_data (write_data),
    .read_data  (read_data),
    .err        (err),
    .notif_intr (notif_intr)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Six tests at most 300 cycles each
  initial begin
    #(6 * 300 * CLK_PERIOD);
    $display("Watchdog expired before the test sequence finished");
    $display("TB FAILED");
    $finish;
  end

  // ----------------------------------------
  // Checks and bus tasks
  // ----------------------------------------
  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (actual === expected)
      else begin
        $display("ERROR %s expected %h actual %h", name, expected, actual);
        errors++;
      end
  endtask

  // Value checks plus failed core assertions
  function automatic int total_errors();
    return errors + i_sha512.i_sha512_core.i_sha512_sva.fail_count;
  endfunction

  // Entered and left 10 ns after a rising edge
  task automatic bus_write(input int waddr, input logic [63:0] data, input logic exp_err);
    cs         = 1'b1;
    we         = 1'b1;
    address    = waddr << 3;
    write_data = data;
    #80;
    check_value($sformatf("err on write 0x%0h", waddr), exp_err, err);
    @(posedge clk);
    #10;
    cs = 1'b0;
    we = 1'b0;
  endtask

  task automatic bus_read(input int waddr, input logic exp_err, output logic [63:0] data);
    cs      = 1'b1;
    we      = 1'b0;
    address = waddr << 3;
    #80;
    // Combinational read data, sampled late in the cycle
    data = read_data;
    check_value($sformatf("err on read 0x%0h", waddr), exp_err, err);
    @(posedge clk);
    #10;
    cs = 1'b0;
  endtask

  task automatic random_gap();
    int n;
    n = {$random(seed)} % 3;
    repeat (n) begin
      @(posedge clk);
      #10;
    end
  endtask

  // Stale VALID lingers one cycle after a command, READY does not
  task automatic poll_done();
    logic [63:0] status;
    int          polls;
    polls = 0;
    do begin
      bus_read(`SHA512_ADDR_STATUS, 1'b0, status);
      polls++;
    end while (status[1:0] != 2'b11 && polls < POLL_LIMIT);
    assert (status[1:0] == 2'b11)
      else begin
        $display("STATUS did not show READY and VALID within %0d polls", POLL_LIMIT);
        errors++;
      end
  endtask

  // ----------------------------------------
  // Message padding and block transfer
  // ----------------------------------------
  task automatic pad_message(input int len);
    int          total;
    logic [63:0] bits;
    total = ((len + 17 + 127) / 128) * 128;
    bits  = 64'(len) * 64'd8;
    for (int i = 0; i < 256; i++) begin
      padded[i] = (i < len) ? msg[i] : 8'h00;
    end
    padded[len] = 8'h80;
    // Bit length, big-endian in the last bytes
    for (int i = 0; i < 8; i++) begin
      padded[total - 1 - i] = bits[8*i +: 8];
    end
    nblocks = total / 128;
  endtask

  function automatic logic [63:0] block_word(input int b, input int idx);
    logic [63:0] word;
    word = '0;
    for (int k = 0; k < 8; k++) begin
      word = {word[55:0], padded[b*128 + idx*8 + k]};
    end
    return word;
  endfunction

  task automatic write_block(input int b);
    int order [0:15];
    int j;
    int tmp;
    for (int i = 0; i < 16; i++) begin
      order[i] = i;
    end
    // Shuffle word order
    for (int i = 15; i > 0; i--) begin
      j        = {$random(seed)} % (i + 1);
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    for (int i = 0; i < 16; i++) begin
      random_gap();
      bus_write(`SHA512_ADDR_BLOCK + order[i], block_word(b, order[i]), 1'b0);
    end
  endtask

  task automatic hash_message(input int len, input logic [1:0] mode, input bit busy_next);
    logic [63:0] cmd;
    pad_message(len);
    for (int b = 0; b < nblocks; b++) begin
      write_block(b);
      random_gap();
      // INIT on the first block, NEXT on later ones
      cmd = {60'd0, mode, (b == 0) ? 2'b01 : 2'b10};
      bus_write(`SHA512_ADDR_CTRL, cmd, 1'b0);
      if (busy_next) begin
        // Core is mid-rounds, this NEXT must be dropped
        bus_write(`SHA512_ADDR_CTRL, {60'd0, mode, 2'b10}, 1'b0);
      end
      poll_done();
    end
  endtask

  task automatic check_digest(input logic [511:0] expected);
    logic [63:0] data;
    for (int i = 0; i < 8; i++) begin
      bus_read(`SHA512_ADDR_DIGEST + i, 1'b0, data);
      check_value($sformatf("digest[%0d]", i), expected[511 - 64*i -: 64], data);
    end
  endtask

  task automatic load_abc();
    msg[0] = "a";
    msg[1] = "b";
    msg[2] = "c";
  endtask

  // 14 groups of 8 letters, each starting one letter later
  task automatic load_two_block();
    for (int g = 0; g < 14; g++) begin
      for (int c = 0; c < 8; c++) begin
        msg[g*8 + c] = 8'(8'h61 + g + c);
      end
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (total_errors() == test_start) begin
      $display("Test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: %0d errors", tests_run, name, total_errors() - test_start);
    end
    test_start = total_errors();
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    logic [63:0] data;
    reset_n    = 1'b0;
    cs         = 1'b0;
    we         = 1'b0;
    address    = '0;
    write_data = '0;
    repeat (2) @(posedge clk);
    #10;
    reset_n = 1'b1;

    bus_read(`SHA512_ADDR_NAME, 1'b0, data);
    check_value("NAME", `SHA512_CORE_NAME, data);
    bus_read(`SHA512_ADDR_VERSION, 1'b0, data);
    check_value("VERSION", `SHA512_CORE_VERSION, data);
    bus_read(`SHA512_ADDR_STATUS, 1'b0, data);
    check_value("STATUS", 64'h1, data);
    check_value("notif_intr", 64'h0, notif_intr);
    end_test("reset values");

    load_abc();
    hash_message(3, MODE_SHA512, 1'b0);
    check_digest(EXP_ABC_512);
    bus_read(`SHA512_ADDR_STATUS, 1'b0, data);
    check_value("STATUS", 64'h3, data);
    check_value("notif_intr", 64'h1, notif_intr);
    bus_write(`SHA512_ADDR_INTR, 64'h1, 1'b0);
    check_value("notif_intr", 64'h0, notif_intr);
    end_test("sha512 abc");

    load_two_block();
    hash_message(112, MODE_SHA512, 1'b1);
    check_digest(EXP_TWO_512);
    end_test("sha512 two blocks");

    load_abc();
    hash_message(3, MODE_SHA384, 1'b0);
    check_digest(EXP_ABC_384);
    hash_message(3, MODE_SHA512_256, 1'b0);
    check_digest(EXP_ABC_256);
    hash_message(3, MODE_SHA512_224, 1'b0);
    check_digest(EXP_ABC_224);
    end_test("truncated variants");

    bus_write(`SHA512_ADDR_CTRL, 64'h10, 1'b0);
    check_digest('0);
    for (int i = 0; i < 16; i++) begin
      bus_read(`SHA512_ADDR_BLOCK + i, 1'b0, data);
      check_value($sformatf("block[%0d]", i), 64'h0, data);
    end
    bus_read(`SHA512_ADDR_STATUS, 1'b0, data);
    check_value("STATUS", 64'h1, data);
    end_test("zeroize");

    bus_read('h05, 1'b1, data);
    bus_read('h30, 1'b1, data);
    bus_write(`SHA512_ADDR_DIGEST, '1, 1'b1);
    bus_write(`SHA512_ADDR_STATUS, '1, 1'b1);
    bus_write(`SHA512_ADDR_NAME, '1, 1'b1);
    bus_write(`SHA512_ADDR_BLOCK + 5, 64'h0123456789abcdef, 1'b0);
    bus_read(`SHA512_ADDR_BLOCK + 5, 1'b0, data);
    check_value("block[5]", 64'h0123456789abcdef, data);
    bus_read(`SHA512_ADDR_DIGEST, 1'b0, data);
    check_value("digest[0]", 64'h0, data);
    bus_read(`SHA512_ADDR_STATUS, 1'b0, data);
    check_value("STATUS", 64'h1, data);
    bus_read(`SHA512_ADDR_NAME, 1'b0, data);
    check_value("NAME", `SHA512_CORE_NAME, data);
    end_test("bus errors");

    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
             total_errors());
    if (total_errors() == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+src
src/sha512_pkg.sv
src/sha512_constants.sv
src/sha512_w_sched.sv
src/sha512_core.sv
src/sha512.sv
bench/sha512_sva.sv
bench/sha512_tb.sv

// ==== src/sha512.sv ====
/* SHA-512 engine top with register bus */
`timescale 1ns/1ps
`include "sha512_defines.svh"

module sha512 (
  input  logic                           clk,
  input  logic                           reset_n,
  input  logic                           cs,
  input  logic                           we,
  input  logic [`SHA512_ADDR_WIDTH-1:0]  address,
  input  sha512_pkg::sha512_word_t       write_data,
  output sha512_pkg::sha512_word_t       read_data,
  output logic                           err,
  output logic                           notif_intr
);
  import sha512_pkg::*;

  localparam int WADDR_W = `SHA512_ADDR_WIDTH - 3;

  logic [WADDR_W-1:0] word_addr;
  logic in_block, in_digest, ctrl_sel, intr_sel;
  logic ctrl_wr, intr_wr, block_wr;
  logic init_pulse, next_pulse, zeroize_pulse;
  logic rd_err, wr_err;

  sha512_word_t [0:`SHA512_BLOCK_WORDS-1]  block_reg;
  sha512_word_t [0:`SHA512_DIGEST_WORDS-1] digest_reg;
  sha512_word_t [0:`SHA512_DIGEST_WORDS-1] core_digest;
  sha512_word_t [0:`SHA512_DIGEST_WORDS-1] mask;
  sha512_mode_e mode_reg;
  sha512_mode_e core_mode;
  logic core_ready, core_digest_valid;
  logic valid_reg, intr_sts, digest_rise;

  // ----------------------------------------
  // Address decode
  // ----------------------------------------
  assign word_addr = address[`SHA512_ADDR_WIDTH-1:3];
  assign in_block  = (word_addr >= `SHA512_ADDR_BLOCK) &&
                     (word_addr < `SHA512_ADDR_BLOCK + `SHA512_BLOCK_WORDS);
  assign in_digest = (word_addr >= `SHA512_ADDR_DIGEST) &&
                     (word_addr < `SHA512_ADDR_DIGEST + `SHA512_DIGEST_WORDS);
  assign ctrl_sel  = (word_addr == `SHA512_ADDR_CTRL);
  assign intr_sel  = (word_addr == `SHA512_ADDR_INTR);

  assign ctrl_wr  = cs & we & ctrl_sel;
  assign intr_wr  = cs & we & intr_sel;
  assign block_wr = cs & we & in_block;

  // Commands dropped while the core is busy
  assign init_pulse    = ctrl_wr & write_data[0] & core_ready;
  assign next_pulse    = ctrl_wr & write_data[1] & core_ready;
  assign zeroize_pulse = ctrl_wr & write_data[4];

  // Mode written with INIT must reach the IV lookup in the same cycle
  assign core_mode = ctrl_wr ? sha512_mode_e'(write_data[3:2]) : mode_reg;

  assign digest_rise = core_digest_valid & ~valid_reg;

  sha512_core i_sha512_core (
    .clk          (clk),
    .reset_n      (reset_n),
    .zeroize      (zeroize_pulse),
    .init_cmd     (init_pulse),
    .next_cmd     (next_pulse),
    .mode         (core_mode),
    .block_msg    (block_reg),
    .ready        (core_ready),
    .digest       (core_digest),
    .digest_valid (core_digest_valid)
  );

  // ----------------------------------------
  // Registers
  // ----------------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      block_reg <= '0;
    end else if (zeroize_pulse) begin
      block_reg <= '0;
    end else if (block_wr) begin
      block_reg[word_addr[3:0]] <= write_data;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      mode_reg <= MODE_SHA512;
    end else if (ctrl_wr) begin
      mode_reg <= sha512_mode_e'(write_data[3:2]);
    end
  end

  // Digest capture on rising digest_valid
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      digest_reg <= '0;
      valid_reg  <= 1'b0;
    end else if (zeroize_pulse) begin
      digest_reg <= '0;
      valid_reg  <= 1'b0;
    end else begin
      valid_reg <= core_digest_valid;
      if (digest_rise) begin
        digest_reg <= core_digest & mask;
      end
    end
  end

  // Notification status, write 1 to clear, set wins
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      intr_sts <= 1'b0;
    end else if (digest_rise) begin
      intr_sts <= 1'b1;
    end else if (intr_wr && write_data[0]) begin
      intr_sts <= 1'b0;
    end
  end

  assign notif_intr = intr_sts;

  // Variant length mask, 32-bit granules
  always_comb begin
    case (mode_reg)
      MODE_SHA512_224: mask = {{7{32'hffffffff}}, {9{32'h00000000}}};
      MODE_SHA512_256: mask = {{8{32'hffffffff}}, {8{32'h00000000}}};
      MODE_SHA384:     mask = {{12{32'hffffffff}}, {4{32'h00000000}}};
      default:         mask = {16{32'hffffffff}};
    endcase
  end

  // ----------------------------------------
  // Read mux and error
  // ----------------------------------------
  always_comb begin
    read_data = '0;
    rd_err    = 1'b0;
    if (in_block) begin
      read_data = block_reg[word_addr[3:0]];
    end else if (in_digest) begin
      read_data = digest_reg[word_addr[2:0]];
    end else begin
      case (word_addr)
        `SHA512_ADDR_NAME:    read_data = `SHA512_CORE_NAME;
        `SHA512_ADDR_VERSION: read_data = `SHA512_CORE_VERSION;
        `SHA512_ADDR_CTRL:    read_data[3:2] = mode_reg;
        `SHA512_ADDR_STATUS:  read_data[1:0] = {valid_reg, core_ready};
        `SHA512_ADDR_INTR:    read_data[0] = intr_sts;
        default:              rd_err = 1'b1;
      endcase
    end
  end

  // Only CTRL, INTR and BLOCK accept writes
  assign wr_err = ~(ctrl_sel | intr_sel | in_block);
  assign err    = cs & (we ? wr_err : rd_err);

endmodule

// ==== src/sha512_constants.sv ====
/* SHA-512 round constants and IVs */
`timescale 1ns/1ps

module sha512_constants (
  input  logic [6:0]                   round,
  input  sha512_pkg::sha512_mode_e     mode,
  output sha512_pkg::sha512_word_t     k,
  output sha512_pkg::sha512_word_t [0:7] h_init
);
  import sha512_pkg::*;

  // ----------------------------------------
  // Round constant table, FIPS 180-4 4.2.3
  // ----------------------------------------
  always_comb begin
    case (round)
      7'd0:  k = 64'h428a2f98d728ae22;
      7'd1:  k = 64'h7137449123ef65cd;
      7'd2:  k = 64'hb5c0fbcfec4d3b2f;
      7'd3:  k = 64'he9b5dba58189dbbc;
      7'd4:  k = 64'h3956c25bf348b538;
      7'd5:  k = 64'h59f111f1b605d019;
      7'd6:  k = 64'h923f82a4af194f9b;
      7'd7:  k = 64'hab1c5ed5da6d8118;
      7'd8:  k = 64'hd807aa98a3030242;
      7'd9:  k = 64'h12835b0145706fbe;
      7'd10: k = 64'h243185be4ee4b28c;
      7'd11: k = 64'h550c7dc3d5ffb4e2;
      7'd12: k = 64'h72be5d74f27b896f;
      7'd13: k = 64'h80deb1fe3b1696b1;
      7'd14: k = 64'h9bdc06a725c71235;
      7'd15: k = 64'hc19bf174cf692694;
      7'd16: k = 64'he49b69c19ef14ad2;
      7'd17: k = 64'hefbe4786384f25e3;
      7'd18: k = 64'h0fc19dc68b8cd5b5;
      7'd19: k = 64'h240ca1cc77ac9c65;
      7'd20: k = 64'h2de92c6f592b0275;
      7'd21: k = 64'h4a7484aa6ea6e483;
      7'd22: k = 64'h5cb0a9dcbd41fbd4;
      7'd23: k = 64'h76f988da831153b5;
      7'd24: k = 64'h983e5152ee66dfab;
      7'd25: k = 64'ha831c66d2db43210;
      7'd26: k = 64'hb00327c898fb213f;
      7'd27: k = 64'hbf597fc7beef0ee4;
      7'd28: k = 64'hc6e00bf33da88fc2;
      7'd29: k = 64'hd5a79147930aa725;
      7'd30: k = 64'h06ca6351e003826f;
      7'd31: k = 64'h142929670a0e6e70;
      7'd32: k = 64'h27b70a8546d22ffc;
      7'd33: k = 64'h2e1b21385c26c926;
      7'd34: k = 64'h4d2c6dfc5ac42aed;
      7'd35: k = 64'h53380d139d95b3df;
      7'd36: k = 64'h650a73548baf63de;
      7'd37: k = 64'h766a0abb3c77b2a8;
      7'd38: k = 64'h81c2c92e47edaee6;
      7'd39: k = 64'h92722c851482353b;
      7'd40: k = 64'ha2bfe8a14cf10364;
      7'd41: k = 64'ha81a664bbc423001;
      7'd42: k = 64'hc24b8b70d0f89791;
      7'd43: k = 64'hc76c51a30654be30;
      7'd44: k = 64'hd192e819d6ef5218;
      7'd45: k = 64'hd69906245565a910;
      7'd46: k = 64'hf40e35855771202a;
      7'd47: k = 64'h106aa07032bbd1b8;
      7'd48: k = 64'h19a4c116b8d2d0c8;
      7'd49: k = 64'h1e376c085141ab53;
      7'd50: k = 64'h2748774cdf8eeb99;
      7'd51: k = 64'h34b0bcb5e19b48a8;
      7'd52: k = 64'h391c0cb3c5c95a63;
      7'd53: k = 64'h4ed8aa4ae3418acb;
      7'd54: k = 64'h5b9cca4f7763e373;
      7'd55: k = 64'h682e6ff3d6b2b8a3;
      7'd56: k = 64'h748f82ee5defb2fc;
      7'd57: k = 64'h78a5636f43172f60;
      7'd58: k = 64'h84c87814a1f0ab72;
      7'd59: k = 64'h8cc702081a6439ec;
      7'd60: k = 64'h90befffa23631e28;
      7'd61: k = 64'ha4506cebde82bde9;
      7'd62: k = 64'hbef9a3f7b2c67915;
      7'd63: k = 64'hc67178f2e372532b;
      7'd64: k = 64'hca273eceea26619c;
      7'd65: k = 64'hd186b8c721c0c207;
      7'd66: k = 64'heada7dd6cde0eb1e;
      7'd67: k = 64'hf57d4f7fee6ed178;
      7'd68: k = 64'h06f067aa72176fba;
      7'd69: k = 64'h0a637dc5a2c898a6;
      7'd70: k = 64'h113f9804bef90dae;
      7'd71: k = 64'h1b710b35131c471b;
      7'd72: k = 64'h28db77f523047d84;
      7'd73: k = 64'h32caab7b40c72493;
      7'd74: k = 64'h3c9ebe0a15c9bebc;
      7'd75: k = 64'h431d67c49c100d4c;
      7'd76: k = 64'h4cc5d4becb3e42b6;
      7'd77: k = 64'h597f299cfc657e2a;
      7'd78: k = 64'h5fcb6fab3ad6faec;
      7'd79: k = 64'h6c44198c4a475817;
      // Rounds past 79 never used
      default: k = '0;
    endcase
  end

  // ----------------------------------------
  // Initial hash values per variant
  // ----------------------------------------
  always_comb begin
    case (mode)
      MODE_SHA512_224: h_init = {64'h8c3d37c819544da2, 64'h73e1996689dcd4d6,
                                 64'h1dfab7ae32ff9c82, 64'h679dd514582f9fcf,
                                 64'h0f6d2b697bd44da8, 64'h77e36f7304c48942,
                                 64'h3f9d85a86a1d36c8, 64'h1112e6ad91d692a1};
      MODE_SHA512_256: h_init = {64'h22312194fc2bf72c, 64'h9f555fa3c84c64c2,
                                 64'h2393b86b6f53b151, 64'h963877195940eabd,
                                 64'h96283ee2a88effe3, 64'hbe5e1e2553863992,
                                 64'h2b0199fc2c85b8aa, 64'h0eb72ddc81c52ca2};
      MODE_SHA384:     h_init = {64'hcbbb9d5dc1059ed8, 64'h629a292a367cd507,
                                 64'h9159015a3070dd17, 64'h152fecd8f70e5939,
                                 64'h67332667ffc00b31, 64'h8eb44a8768581511,
                                 64'hdb0c2e0d64f98fa7, 64'h47b5481dbefa4fa4};
      default:         h_init = {64'h6a09e667f3bcc908, 64'hbb67ae8584caa73b,
                                 64'h3c6ef372fe94f82b, 64'ha54ff53a5f1d36f1,
                                 64'h510e527fade682d1, 64'h9b05688c2b3e6c1f,
                                 64'h1f83d9abfb41bd6b, 64'h5be0cd19137e2179};
    endcase
  end

endmodule

// ==== src/sha512_core.sv ====
/* SHA-512 compression core */
`timescale 1ns/1ps
`include "sha512_defines.svh"

module sha512_core (
  input  logic                           clk,
  input  logic                           reset_n,
  input  logic                           zeroize,
  input  logic                           init_cmd,
  input  logic                           next_cmd,
  input  sha512_pkg::sha512_mode_e       mode,
  input  logic [`SHA512_BLOCK_WIDTH-1:0] block_msg,
  output logic                           ready,
  output sha512_pkg::sha512_word_t [0:`SHA512_DIGEST_WORDS-1] digest,
  output logic                           digest_valid
);
  import sha512_pkg::*;

  core_state_e  state;
  logic [6:0]   round;
  logic         accept;

  // Running hash H0..H7 and working variables a..h
  sha512_word_t [0:`SHA512_DIGEST_WORDS-1] hash;
  sha512_word_t [0:`SHA512_DIGEST_WORDS-1] wv;
  sha512_word_t [0:`SHA512_DIGEST_WORDS-1] h_init;

  sha512_word_t k;
  sha512_word_t w;
  sha512_word_t sum0;
  sha512_word_t sum1;
  sha512_word_t ch;
  sha512_word_t maj;
  sha512_word_t t1;
  sha512_word_t t2;

  // ----------------------------------------
  // Constants and schedule
  // ----------------------------------------
  sha512_constants i_sha512_constants (
    .round  (round),
    .mode   (mode),
    .k      (k),
    .h_init (h_init)
  );

  sha512_w_sched i_sha512_w_sched (
    .clk       (clk),
    .reset_n   (reset_n),
    .zeroize   (zeroize),
    .load      (accept),
    .step      (state == CORE_ROUNDS),
    .block_msg (block_msg),
    .round     (round),
    .w         (w)
  );

  // Commands only count while idle
  assign accept = (init_cmd | next_cmd) & (state == CORE_IDLE);

  // ----------------------------------------
  // Round function
  // ----------------------------------------
  // Big sigma1 of e
  assign sum1 = {wv[4][13:0], wv[4][63:14]} ^ {wv[4][17:0], wv[4][63:18]}
              ^ {wv[4][40:0], wv[4][63:41]};
  // Big sigma0 of a
  assign sum0 = {wv[0][27:0], wv[0][63:28]} ^ {wv[0][33:0], wv[0][63:34]}
              ^ {wv[0][38:0], wv[0][63:39]};
  assign ch   = (wv[4] & wv[5]) ^ (~wv[4] & wv[6]);
  assign maj  = (wv[0] & wv[1]) ^ (wv[0] & wv[2]) ^ (wv[1] & wv[2]);
  assign t1   = wv[7] + sum1 + ch + k + w;
  assign t2   = sum0 + maj;

  // ----------------------------------------
  // FSM and datapath registers
  // ----------------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state        <= CORE_IDLE;
      round        <= '0;
      hash         <= '0;
      wv           <= '0;
      digest_valid <= 1'b0;
    end else if (zeroize) begin
      state        <= CORE_IDLE;
      round        <= '0;
      hash         <= '0;
      wv           <= '0;
      digest_valid <= 1'b0;
    end else begin
      case (state)
        CORE_IDLE: begin
          if (accept) begin
            // INIT restarts from the variant IV, NEXT chains on
            if (init_cmd) begin
              hash <= h_init;
              wv   <= h_init;
            end else begin
              wv <= hash;
            end
            round        <= '0;
            digest_valid <= 1'b0;
            state        <= CORE_ROUNDS;
          end
        end
        CORE_ROUNDS: begin
          // a <= t1+t2, e <= d+t1, the rest shift down
          wv <= {t1 + t2, wv[0], wv[1], wv[2], wv[3] + t1, wv[4], wv[5], wv[6]};
          if (round == 7'(`SHA512_ROUNDS - 1)) begin
            state <= CORE_DONE;
          end else begin
            round <= round + 7'd1;
          end
        end
        CORE_DONE: begin
          // Fold working vars back into hash
          for (int i = 0; i < `SHA512_DIGEST_WORDS; i++) begin
            hash[i] <= hash[i] + wv[i];
          end
          digest_valid <= 1'b1;
          state        <= CORE_IDLE;
        end
        default: state <= CORE_IDLE;
      endcase
    end
  end

  assign ready  = (state == CORE_IDLE);
  assign digest = hash;

endmodule

// ==== src/sha512_defines.svh ====
/* SHA-512 engine register map and widths */
`ifndef SHA512_DEFINES_SVH
`define SHA512_DEFINES_SVH

// Bus widths
`define SHA512_DATA_WIDTH   64
`define SHA512_ADDR_WIDTH   32

// Block and digest sizes
`define SHA512_BLOCK_WIDTH  1024
`define SHA512_BLOCK_WORDS  16
`define SHA512_DIGEST_WORDS 8
`define SHA512_ROUNDS       80

// Word addresses, byte address bits 2:0 dropped
`define SHA512_ADDR_NAME    'h00
`define SHA512_ADDR_VERSION 'h01
`define SHA512_ADDR_CTRL    'h02
`define SHA512_ADDR_STATUS  'h03
`define SHA512_ADDR_INTR    'h04
`define SHA512_ADDR_BLOCK   'h10
`define SHA512_ADDR_DIGEST  'h20

// Identification words ("sha2-512" and 1.0)
`define SHA512_CORE_NAME    64'h3231352d_32616873
`define SHA512_CORE_VERSION 64'h00000001_00000000

`endif

// ==== src/sha512_pkg.sv ====
/* SHA-512 shared types */
`include "sha512_defines.svh"

package sha512_pkg;

  // One bus and hash word
  typedef logic [`SHA512_DATA_WIDTH-1:0] sha512_word_t;

  // Hash variant, encoding matches CTRL.MODE
  typedef enum logic [1:0] {
    MODE_SHA512_224 = 2'd0,
    MODE_SHA512_256 = 2'd1,
    MODE_SHA384     = 2'd2,
    MODE_SHA512     = 2'd3
  } sha512_mode_e;

  // Compression FSM
  typedef enum logic [1:0] {
    CORE_IDLE   = 2'd0,
    CORE_ROUNDS = 2'd1,
    CORE_DONE   = 2'd2
  } core_state_e;

endpackage

// ==== src/sha512_w_sched.sv ====
/* SHA-512 message schedule */
`timescale 1ns/1ps
`include "sha512_defines.svh"

module sha512_w_sched (
  input  logic                           clk,
  input  logic                           reset_n,
  input  logic                           zeroize,
  input  logic                           load,
  input  logic                           step,
  input  logic [`SHA512_BLOCK_WIDTH-1:0] block_msg,
  input  logic [6:0]                     round,
  output sha512_pkg::sha512_word_t       w
);
  import sha512_pkg::*;

  // Window holds W[t-16] .. W[t-1], word 0 oldest
  sha512_word_t [0:`SHA512_BLOCK_WORDS-1] win;
  sha512_word_t s0;
  sha512_word_t s1;
  sha512_word_t w_new;
  logic         from_block;

  // Small sigma0 on W[t-15]
  assign s0 = {win[1][0], win[1][63:1]} ^ {win[1][7:0], win[1][63:8]} ^ (win[1] >> 7);

  // Small sigma1 on W[t-2]
  assign s1 = {win[14][18:0], win[14][63:19]} ^ {win[14][60:0], win[14][63:61]}
            ^ (win[14] >> 6);

  assign w_new = s1 + win[9] + s0 + win[0];

  // First 16 rounds read the block straight from the window
  assign from_block = (round < `SHA512_BLOCK_WORDS);
  assign w = from_block ? win[round[3:0]] : w_new;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      win <= '0;
    end else if (zeroize) begin
      win <= '0;
    end else if (load) begin
      // Word 0 is the MSB end of the block
      win <= block_msg;
    end else if (step && !from_block) begin
      // Slide window by one word
      win <= {win[1:`SHA512_BLOCK_WORDS-1], w_new};
    end
  end

endmodule
